// File: include/matmul_defines.svh
`ifndef MATMUL_DEFINES_SVH
`define MATMUL_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// Array geometry
////////////////////////////////////////////////////////////////////////////

// Matrix dimension, the array is MAT_SIZE by MAT_SIZE cells
`define MAT_SIZE 4
// Width of a column index, must match MAT_SIZE
`define LOG2_MAT_SIZE 2

////////////////////////////////////////////////////////////////////////////
// Data and memory widths
////////////////////////////////////////////////////////////////////////////

// Signed element width
`define DWIDTH 8
`define AWIDTH 10
`define STRIDE_WIDTH 8

// Cycles from a read address to its returned data
`define MEM_LATENCY 1
// Operand register, product register, sum register
`define MAC_CYCLES 3

`endif

// File: design/matmul_pkg.sv
`include "matmul_defines.svh"

package matmul_pkg;

  // One signed matrix element
  typedef logic signed [`DWIDTH-1:0] data_t;

  // Memory address and the step between consecutive vectors
  typedef logic [`AWIDTH-1:0] addr_t;
  typedef logic [`STRIDE_WIDTH-1:0] stride_t;

  // One memory word, lane 0 sits in the lowest bits
  typedef struct packed {
    data_t [`MAT_SIZE-1:0] lane;
  } vec_t;

  // Row i of the matrix holds Cij for j = 0..MAT_SIZE-1
  typedef vec_t [`MAT_SIZE-1:0] matrix_t;

  // Where an operand or the result lives in memory
  typedef struct packed {
    addr_t   base;
    stride_t stride;
  } operand_cfg_t;

  // One result column with its write address
  typedef struct packed {
    logic  valid;
    addr_t addr;
    vec_t  data;
  } result_t;

  // Sequencer states, in the order a run walks through them
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_FETCH,
    ST_COMPUTE,
    ST_DRAIN,
    ST_DONE
  } seq_state_t;

endpackage

// File: design/operand_feeder.sv
`timescale 1ns/1ps
`include "matmul_defines.svh"

module operand_feeder (
  input  logic                     clk,
  input  logic                     i_clear,
  input  logic                     i_fetch,
  input  matmul_pkg::operand_cfg_t i_cfg,
  input  matmul_pkg::vec_t         i_mem_data,
  output matmul_pkg::addr_t        o_mem_addr,
  output matmul_pkg::vec_t         o_lanes
);
  import matmul_pkg::*;

  addr_t                   addr_q;
  logic [`MEM_LATENCY-1:0] vld_sr;
  logic                    data_valid;
  vec_t                    masked;

  ////////////////////////////////////////////////////////////////////////////
  // Read address generation
  ////////////////////////////////////////////////////////////////////////////

  // The register sits at the base while idle, so the first fetch cycle
  // presents the base and each fetch cycle steps it by one stride
  always_ff @(posedge clk) begin
    if (i_clear) begin
      addr_q <= i_cfg.base;
    end else if (i_fetch) begin
      addr_q <= addr_q + addr_t'(i_cfg.stride);
    end
  end

  assign o_mem_addr = addr_q;

  ////////////////////////////////////////////////////////////////////////////
  // Data qualification
  ////////////////////////////////////////////////////////////////////////////

  // A copy of the fetch window, delayed by the memory latency
  always_ff @(posedge clk) begin
    if (i_clear) begin
      vld_sr <= '0;
    end else begin
      vld_sr[0] <= i_fetch;
      for (int k = 1; k < `MEM_LATENCY; k++) begin
        vld_sr[k] <= vld_sr[k-1];
      end
    end
  end

  assign data_valid = vld_sr[`MEM_LATENCY-1];

  // Whatever the memory returns outside the window is forced to zero, so
  // the array only ever accumulates real operands
  always_comb begin
    for (int k = 0; k < `MAT_SIZE; k++) begin
      masked.lane[k] = data_valid ? i_mem_data.lane[k] : '0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Systolic skew
  ////////////////////////////////////////////////////////////////////////////

  // Lane k passes through k registers so that operands meet in the array
  for (genvar k = 0; k < `MAT_SIZE; k++) begin : g_skew
    if (k == 0) begin : g_direct
      assign o_lanes.lane[k] = masked.lane[k];
    end else begin : g_delay
      data_t taps [k];

      always_ff @(posedge clk) begin
        if (i_clear) begin
          for (int t = 0; t < k; t++) begin
            taps[t] <= '0;
          end
        end else begin
          taps[0] <= masked.lane[k];
          for (int t = 1; t < k; t++) begin
            taps[t] <= taps[t-1];
          end
        end
      end

      assign o_lanes.lane[k] = taps[k-1];
    end
  end

endmodule

// File: design/processing_element.sv
`timescale 1ns/1ps
`include "matmul_defines.svh"

module processing_element (
  input  logic              clk,
  input  logic              i_clear,
  input  matmul_pkg::data_t i_a,
  input  matmul_pkg::data_t i_b,
  output matmul_pkg::data_t o_a,
  output matmul_pkg::data_t o_b,
  output matmul_pkg::data_t o_sum
);
  import matmul_pkg::*;

  // Limits of the signed element range
  localparam int SAT_MAX = 2 ** (`DWIDTH - 1) - 1;
  localparam int SAT_MIN = -(2 ** (`DWIDTH - 1));

  data_t                       a_q;
  data_t                       b_q;
  logic signed [2*`DWIDTH-1:0] prod_q;
  data_t                       prod_sat;
  data_t                       sum_q;

  // First stage registers the operands, and the same registers feed the
  // east and south neighbours one cycle later
  always_ff @(posedge clk) begin
    if (i_clear) begin
      a_q <= '0;
      b_q <= '0;
    end else begin
      a_q <= i_a;
      b_q <= i_b;
    end
  end

  assign o_a = a_q;
  assign o_b = b_q;

  // Second stage holds the full width signed product
  always_ff @(posedge clk) begin
    if (i_clear) begin
      prod_q <= '0;
    end else begin
      prod_q <= a_q * b_q;
    end
  end

  // Clamp the product back into the element range
  always_comb begin
    if (prod_q > SAT_MAX) begin
      prod_sat = data_t'(SAT_MAX);
    end else if (prod_q < SAT_MIN) begin
      prod_sat = data_t'(SAT_MIN);
    end else begin
      prod_sat = data_t'(prod_q);
    end
  end

  // Third stage accumulates, the sum simply wraps at the element width
  always_ff @(posedge clk) begin
    if (i_clear) begin
      sum_q <= '0;
    end else begin
      sum_q <= sum_q + prod_sat;
    end
  end

  assign o_sum = sum_q;

endmodule

// File: design/systolic_array.sv
`timescale 1ns/1ps
`include "matmul_defines.svh"

module systolic_array (
  input  logic                clk,
  input  logic                i_clear,
  input  matmul_pkg::vec_t    i_west,
  input  matmul_pkg::vec_t    i_north,
  output matmul_pkg::matrix_t o_sum
);
  import matmul_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Operand links between neighbouring cells
  ////////////////////////////////////////////////////////////////////////////

  // a_link[i][j] enters cell (i,j) from the west, and the extra column
  // holds what falls off the east edge
  data_t a_link [`MAT_SIZE][`MAT_SIZE+1];
  // b_link[i][j] enters cell (i,j) from the north, and the extra row
  // holds what falls off the south edge
  data_t b_link [`MAT_SIZE+1][`MAT_SIZE];

  // West lane i drives row i
  for (genvar i = 0; i < `MAT_SIZE; i++) begin : g_west
    assign a_link[i][0] = i_west.lane[i];
  end

  // North lane j drives column j
  for (genvar j = 0; j < `MAT_SIZE; j++) begin : g_north
    assign b_link[0][j] = i_north.lane[j];
  end

  ////////////////////////////////////////////////////////////////////////////
  // Cell grid
  ////////////////////////////////////////////////////////////////////////////

  // Cell (i,j) sees Aik and Bkj in the same cycle and owns Cij
  for (genvar i = 0; i < `MAT_SIZE; i++) begin : g_row
    for (genvar j = 0; j < `MAT_SIZE; j++) begin : g_col
      processing_element pe_inst (
        .clk     (clk),
        .i_clear (i_clear),
        .i_a     (a_link[i][j]),
        .i_b     (b_link[i][j]),
        .o_a     (a_link[i][j+1]),
        .o_b     (b_link[i+1][j]),
        // Sums land straight in row i, lane j of the result matrix
        .o_sum   (o_sum[i].lane[j])
      );
    end
  end

endmodule

// File: design/matmul_sequencer.sv
`timescale 1ns/1ps
`include "matmul_defines.svh"

module matmul_sequencer (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     i_clear,
  input  matmul_pkg::operand_cfg_t i_c_cfg,
  input  matmul_pkg::matrix_t      i_sum,
  output logic                     o_fetch,
  output matmul_pkg::result_t      o_result,
  output logic                     o_done
);
  import matmul_pkg::*;

  // Count of the last fetch cycle, fetching starts one cycle after start
  localparam int FETCH_LAST = `MAT_SIZE;
  // First cycle with every sum final. The last vector is fetched MAT_SIZE-1
  // cycles after the first, its last lane is skewed MAT_SIZE-1 cycles and
  // it hops MAT_SIZE-1 cells to reach the far corner
  localparam int DRAIN_FIRST = 1 + 3 * (`MAT_SIZE - 1) + `MEM_LATENCY + `MAC_CYCLES;
  localparam int CNT_W = $clog2(DRAIN_FIRST + 1);

  seq_state_t                state_q;
  seq_state_t                state_d;
  logic [CNT_W-1:0]          cnt_q;
  logic [`LOG2_MAT_SIZE-1:0] col_q;
  addr_t                     c_addr_q;
  logic                      last_col;
  logic                      done_q;

  assign last_col = (col_q == `LOG2_MAT_SIZE'(`MAT_SIZE - 1));

  ////////////////////////////////////////////////////////////////////////////
  // State machine
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    if (i_clear) begin
      state_d = ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE:    state_d = ST_FETCH;
        ST_FETCH:   if (cnt_q == CNT_W'(FETCH_LAST)) state_d = ST_COMPUTE;
        ST_COMPUTE: if (cnt_q == CNT_W'(DRAIN_FIRST - 1)) state_d = ST_DRAIN;
        ST_DRAIN:   if (last_col) state_d = ST_DONE;
        // Parked here until start drops
        ST_DONE:    state_d = ST_DONE;
        default:    state_d = ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Cycle counter runs from the first start cycle and freezes once draining
  always_ff @(posedge clk) begin
    if (i_clear) begin
      cnt_q <= '0;
    end else if (state_q != ST_DRAIN && state_q != ST_DONE) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign o_fetch = (state_q == ST_FETCH);

  ////////////////////////////////////////////////////////////////////////////
  // Result drain
  ////////////////////////////////////////////////////////////////////////////

  // Column index and write address step together, one column per cycle
  always_ff @(posedge clk) begin
    if (i_clear) begin
      col_q    <= '0;
      c_addr_q <= i_c_cfg.base;
    end else if (state_q == ST_DRAIN) begin
      col_q    <= col_q + 1'b1;
      c_addr_q <= c_addr_q + addr_t'(i_c_cfg.stride);
    end
  end

  // Lane i of the outgoing word is Cij for the current column j
  always_comb begin
    o_result.valid = (state_q == ST_DRAIN);
    o_result.addr  = c_addr_q;
    for (int r = 0; r < `MAT_SIZE; r++) begin
      o_result.data.lane[r] = i_sum[r].lane[col_q];
    end
  end

  // Done fires in the cycle right after the last column
  always_ff @(posedge clk) begin
    if (i_clear) begin
      done_q <= 1'b0;
    end else begin
      done_q <= (state_q == ST_DRAIN) && last_col;
    end
  end

  assign o_done = done_q;

endmodule

// File: design/matmul_top.sv
`timescale 1ns/1ps

module matmul_top (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     i_start,
  input  matmul_pkg::operand_cfg_t i_a_cfg,
  input  matmul_pkg::operand_cfg_t i_b_cfg,
  input  matmul_pkg::operand_cfg_t i_c_cfg,
  input  matmul_pkg::vec_t         i_a_data,
  input  matmul_pkg::vec_t         i_b_data,
  output matmul_pkg::addr_t        o_a_addr,
  output matmul_pkg::addr_t        o_b_addr,
  output matmul_pkg::result_t      o_result,
  output logic                     o_done
);
  import matmul_pkg::*;

  logic    clear;
  logic    fetch;
  vec_t    a_west;
  vec_t    b_north;
  matrix_t c_sum;

  // Start is a level, so any idle cycle wipes the whole datapath,
  // accumulators included
  assign clear = reset | ~i_start;

  ////////////////////////////////////////////////////////////////////////////
  // Operand feeders
  ////////////////////////////////////////////////////////////////////////////

  // A words are columns of A, lane i feeds array row i
  operand_feeder a_feeder (
    .clk        (clk),
    .i_clear    (clear),
    .i_fetch    (fetch),
    .i_cfg      (i_a_cfg),
    .i_mem_data (i_a_data),
    .o_mem_addr (o_a_addr),
    .o_lanes    (a_west)
  );

  // B words are rows of B, lane j feeds array column j
  operand_feeder b_feeder (
    .clk        (clk),
    .i_clear    (clear),
    .i_fetch    (fetch),
    .i_cfg      (i_b_cfg),
    .i_mem_data (i_b_data),
    .o_mem_addr (o_b_addr),
    .o_lanes    (b_north)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Array and control
  ////////////////////////////////////////////////////////////////////////////

  systolic_array systolic_array_inst (
    .clk     (clk),
    .i_clear (clear),
    .i_west  (a_west),
    .i_north (b_north),
    .o_sum   (c_sum)
  );

  matmul_sequencer matmul_sequencer_inst (
    .clk      (clk),
    .reset    (reset),
    .i_clear  (clear),
    .i_c_cfg  (i_c_cfg),
    .i_sum    (c_sum),
    .o_fetch  (fetch),
    .o_result (o_result),
    .o_done   (o_done)
  );

endmodule

// File: testbench/matmul_sva.sv
`timescale 1ns/1ps

module matmul_sva (
  input logic                clk,
  input logic                reset,
  input logic                i_start,
  input matmul_pkg::result_t i_result,
  input logic                i_done
);
  import matmul_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Port protocol
  ////////////////////////////////////////////////////////////////////////////

  // Done is a single cycle pulse
  a_done_pulse: assert property (
    @(posedge clk) disable iff (reset) i_done |=> !i_done
  ) else $error("o_done stayed high for more than one cycle");

  // With start low the whole design is held clear, so the result port is quiet
  a_idle_quiet: assert property (
    @(posedge clk) disable iff (reset) !i_start |-> !i_result.valid && !i_done
  ) else $error("result port active while i_start is low");

  // Done follows the last column and never overlaps a column
  a_done_alone: assert property (
    @(posedge clk) disable iff (reset) i_done |-> !i_result.valid
  ) else $error("o_result.valid high in the o_done cycle");

endmodule

// File: testbench/matmul_tb.sv
`timescale 1ns/1ps
`include "matmul_defines.svh"

module matmul_tb;
  import matmul_pkg::*;

  typedef enum logic [1:0] {FILL_IDENT, FILL_RANDOM, FILL_EXTREME} fill_t;

  // One table row, with operand placement, data flavour and expected column count
  typedef struct packed {
    operand_cfg_t a_cfg;
    operand_cfg_t b_cfg;
    operand_cfg_t c_cfg;
    fill_t        fill;
    logic [3:0]   n_cols;
  } test_t;

  localparam int NUM_TESTS       = 5;
  localparam int WATCHDOG_CYCLES = 8 + NUM_TESTS * 100;

  logic         clk;
  logic         reset;
  logic         i_start;
  operand_cfg_t i_a_cfg;
  operand_cfg_t i_b_cfg;
  operand_cfg_t i_c_cfg;
  vec_t         i_a_data;
  vec_t         i_b_data;
  addr_t        o_a_addr;
  addr_t        o_b_addr;
  result_t      o_result;
  logic         o_done;

  test_t        tests [NUM_TESTS];
  vec_t         a_mem [2**`AWIDTH];
  vec_t         b_mem [2**`AWIDTH];
  // Addresses in flight through the memory model
  addr_t        a_pend [$];
  addr_t        b_pend [$];
  data_t        a_m [`MAT_SIZE][`MAT_SIZE];
  data_t        b_m [`MAT_SIZE][`MAT_SIZE];
  data_t        c_m [`MAT_SIZE][`MAT_SIZE];
  logic [31:0]  lcg_state = 32'heddbd136;

  matmul_top matmul_top_inst (
    .clk      (clk),
    .reset    (reset),
    .i_start  (i_start),
    .i_a_cfg  (i_a_cfg),
    .i_b_cfg  (i_b_cfg),
    .i_c_cfg  (i_c_cfg),
    .i_a_data (i_a_data),
    .i_b_data (i_b_data),
    .o_a_addr (o_a_addr),
    .o_b_addr (o_b_addr),
    .o_result (o_result),
    .o_done   (o_done)
  );

  bind matmul_top matmul_sva matmul_sva_inst (
    .clk      (clk),
    .reset    (reset),
    .i_start  (i_start),
    .i_result (o_result),
    .i_done   (o_done)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Memory model and watchdog
  ////////////////////////////////////////////////////////////////////////////

  // The address is taken mid cycle and its word comes back MEM_LATENCY cycles on
  always @(negedge clk) begin
    a_pend.push_back(o_a_addr);
    b_pend.push_back(o_b_addr);
  end

  always @(posedge clk) begin
    #2;
    if (a_pend.size() >= `MEM_LATENCY) begin
      i_a_data = a_mem[a_pend.pop_front()];
      i_b_data = b_mem[b_pend.pop_front()];
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("sim failed");
    $fatal(1);
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus and reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Extreme mode leans hard on the two ends of the signed range
  function automatic data_t pick_element(fill_t fill);
    logic [31:0] r;
    data_t       v;
    r = lcg_next();
    v = data_t'(r[23:16]);
    if (fill == FILL_EXTREME && r[25:24] == 2'd0) v = 8'sh80;
    if (fill == FILL_EXTREME && r[25:24] == 2'd1) v = 8'sh7f;
    return v;
  endfunction

  // Vector k of an operand lives at base + k*stride, wrapping in the address space
  function automatic addr_t stepped_addr(operand_cfg_t cfg, int k);
    return cfg.base + addr_t'(k * int'(cfg.stride));
  endfunction

  task automatic load_operands(test_t t);
    int    p;
    data_t acc;
    // Background words depend on the full address, so a stray read shows up
    for (int n = 0; n < 2**`AWIDTH; n++) begin
      a_mem[n] = vec_t'(n * 32'h9e3779b1);
      b_mem[n] = vec_t'(~(n * 32'h85ebca6b));
    end
    for (int i = 0; i < `MAT_SIZE; i++) begin
      for (int k = 0; k < `MAT_SIZE; k++) begin
        a_m[i][k] = pick_element(t.fill);
        if (t.fill == FILL_IDENT) begin
          a_m[i][k] = (i == k) ? 8'sd1 : 8'sd0;
        end
        b_m[i][k] = pick_element(t.fill);
      end
    end
    // A words are columns of A, B words are rows of B
    for (int k = 0; k < `MAT_SIZE; k++) begin
      for (int l = 0; l < `MAT_SIZE; l++) begin
        a_mem[stepped_addr(t.a_cfg, k)].lane[l] = a_m[l][k];
        b_mem[stepped_addr(t.b_cfg, k)].lane[l] = b_m[k][l];
      end
    end
    // Each product is clamped to the element range, the running sum wraps
    for (int i = 0; i < `MAT_SIZE; i++) begin
      for (int j = 0; j < `MAT_SIZE; j++) begin
        acc = '0;
        for (int k = 0; k < `MAT_SIZE; k++) begin
          p = int'(a_m[i][k]) * int'(b_m[k][j]);
          p = (p > 127) ? 127 : ((p < -128) ? -128 : p);
          acc = acc + data_t'(p);
        end
        c_m[i][j] = acc;
      end
    end
  endtask

  function automatic vec_t expected_column(test_t t, int j);
    vec_t v;
    for (int i = 0; i < `MAT_SIZE; i++) begin
      // An identity A passes B straight through
      v.lane[i] = (t.fill == FILL_IDENT) ? b_m[i][j] : c_m[i][j];
    end
    return v;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_addr(string name, addr_t got, addr_t exp);
    if (got !== exp) begin
      $display("error %s: got %h, expected %h", name, got, exp);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  task automatic check_vec(string name, vec_t got, vec_t exp);
    if (got !== exp) begin
      $display("error %s: got %h, expected %h", name, got, exp);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("error %s: got %h, expected %h", name, got, exp);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  task automatic abort_run(string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic run_test(test_t t);
    int   a_k;
    int   b_k;
    int   cols;
    logic done_seen;
    // Start stays low for one cycle while the new operands and configs settle
    @(posedge clk);
    #2;
    i_start = 1'b0;
    load_operands(t);
    i_a_cfg = t.a_cfg;
    i_b_cfg = t.b_cfg;
    i_c_cfg = t.c_cfg;
    @(posedge clk);
    #2;
    i_start   = 1'b1;
    a_k       = 0;
    b_k       = 0;
    cols      = 0;
    done_seen = 1'b0;
    for (int cyc = 0; cyc < 60 && !done_seen; cyc++) begin
      @(negedge clk);
      // Read addresses only move forward through base + k*stride
      if (o_a_addr !== stepped_addr(t.a_cfg, a_k) && a_k < `MAT_SIZE) a_k++;
      if (o_b_addr !== stepped_addr(t.b_cfg, b_k) && b_k < `MAT_SIZE) b_k++;
      check_addr("o_a_addr", o_a_addr, stepped_addr(t.a_cfg, a_k));
      check_addr("o_b_addr", o_b_addr, stepped_addr(t.b_cfg, b_k));
      if (o_result.valid === 1'b1) begin
        if (cols >= int'(t.n_cols)) abort_run("more result columns than expected");
        check_addr("o_result.addr", o_result.addr, stepped_addr(t.c_cfg, cols));
        check_vec("o_result.data", o_result.data, expected_column(t, cols));
        cols++;
      end
      done_seen = (o_done === 1'b1);
    end
    if (!done_seen) abort_run("o_done never pulsed after start was raised");
    if (cols != int'(t.n_cols)) abort_run("wrong number of result columns before o_done");
    if (t.a_cfg.stride != 0 && a_k < `MAT_SIZE - 1) abort_run("A reads never reached row 3");
    if (t.b_cfg.stride != 0 && b_k < `MAT_SIZE - 1) abort_run("B reads never reached row 3");
    // The pulse is over one cycle later and nothing else streams out
    @(negedge clk);
    check_flag("o_done", o_done, 1'b0);
    check_flag("o_result.valid", o_result.valid, 1'b0);
  endtask

  initial begin
    reset    = 1'b1;
    i_start  = 1'b0;
    i_a_cfg  = '0;
    i_b_cfg  = '0;
    i_c_cfg  = '0;
    i_a_data = '0;
    i_b_data = '0;
    tests[0] = '{'{10'd0, 8'd1}, '{10'd64, 8'd2}, '{10'd200, 8'd4}, FILL_IDENT, 4'd4};
    tests[1] = '{'{10'd16, 8'd8}, '{10'd300, 8'd3}, '{10'd500, 8'd1}, FILL_RANDOM, 4'd4};
    tests[2] = '{'{10'd100, 8'd17}, '{10'd600, 8'd5}, '{10'd900, 8'd9}, FILL_EXTREME, 4'd4};
    tests[3] = '{'{10'd1000, 8'd7}, '{10'd0, 8'd255}, '{10'd10, 8'd0}, FILL_EXTREME, 4'd4};
    tests[4] = '{'{10'd50, 8'd1}, '{10'd51, 8'd1}, '{10'd1020, 8'd3}, FILL_RANDOM, 4'd4};
    // Seven checks between edges, then the eighth edge ends reset
    repeat (7) begin
      @(negedge clk);
      check_flag("o_result.valid", o_result.valid, 1'b0);
      check_flag("o_done", o_done, 1'b0);
    end
    @(posedge clk);
    #2;
    reset = 1'b0;
    @(negedge clk);
    check_flag("o_result.valid", o_result.valid, 1'b0);
    check_flag("o_done", o_done, 1'b0);
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(tests[t]);
    end
    $display("sim passed");
    $finish;
  end

endmodule

// File: tb.f
+incdir+include
design/matmul_pkg.sv
design/operand_feeder.sv
design/processing_element.sv
design/systolic_array.sv
design/matmul_sequencer.sv
design/matmul_top.sv
testbench/matmul_sva.sv
testbench/matmul_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  -f tb.f \
  --top-module matmul_tb \
  -o matmul_sim
./obj_dir/matmul_sim
